// File: all.f
logic/eeprom_cmd_pkg.sv
logic/eeprom_bus_pkg.sv
logic/eeprom_cmd_fifo.sv
logic/eeprom_cond_gen.sv
logic/eeprom_byte_shifter.sv
logic/eeprom_sequencer.sv
logic/eeprom_ctrl_top.sv
verification/eeprom_model.sv
verification/eeprom_ctrl_sva.sv
verification/tb_eeprom_ctrl.sv

// File: Makefile
SIM      = verilator
TOP      = tb_eeprom_ctrl
FILELIST = all.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)

BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// File: verification/eeprom_stimulus.txt
# columns, all hex: op (0 write, 1 read), address, write data, expected read data, expected nack
0 123 5a 00 0
1 123 00 5a 0
1 456 00 ff 0
0 600 11 00 1
1 7ff 00 00 1
0 0a5 c3 00 0
1 0a5 00 c3 0
0 5ff 81 00 0
0 000 3c 00 0
1 5ff 00 81 0
1 000 00 3c 0
1 655 00 00 1
0 123 a7 00 0
1 123 00 a7 0
1 2e0 00 ff 0

// File: verification/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;

    localparam int CMD_DEPTH   = 4;
    localparam int RSP_CREDITS = 2;
    localparam int QTR_CYCLES  = 4;
    localparam int TIMEOUT     = 20000; // cycles per wait

    logic                                CLK;
    logic                                RESET;
    logic                                cmd_valid;
    eeprom_cmd_pkg::cmd_op_t             cmd_op;
    logic [eeprom_cmd_pkg::ADDR_W-1:0]   cmd_addr;
    logic [eeprom_cmd_pkg::DATA_W-1:0]   cmd_wdata;
    logic                                cmd_credit;
    logic                                rsp_valid;
    logic [eeprom_cmd_pkg::DATA_W-1:0]   rsp_rdata;
    logic                                rsp_nack;
    logic                                rsp_credit;
    logic                                scl_low;
    logic                                sda_low;
    logic                                model_sda_low;
    wire                                 scl;
    wire                                 sda;

    eeprom_cmd_pkg::cmd_op_t             op_q[$];
    logic [eeprom_cmd_pkg::ADDR_W-1:0]   addr_q[$];
    logic [eeprom_cmd_pkg::DATA_W-1:0]   wdata_q[$];
    logic [eeprom_cmd_pkg::DATA_W-1:0]   exp_rdata_q[$];
    logic                                exp_nack_q[$];
    logic [eeprom_cmd_pkg::DATA_W-1:0]   got_rdata_q[$];
    logic                                got_nack_q[$];

    int     cmd_spent;
    int     cmd_returned;
    int     rsp_given;
    int     rsp_seen;
    integer seed = 29855;

    // pulled up lines that either side pulls low
    assign scl = !scl_low;
    assign sda = !(sda_low || model_sda_low);

    eeprom_ctrl_top #(
        .CMD_DEPTH   (CMD_DEPTH),
        .RSP_CREDITS (RSP_CREDITS),
        .QTR_CYCLES  (QTR_CYCLES)
    ) u_dut (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_nack   (rsp_nack),
        .rsp_credit (rsp_credit),
        .scl_low    (scl_low),
        .sda_low    (sda_low),
        .sda_in     (sda)
    );

    eeprom_model u_model (
        .scl     (scl),
        .sda     (sda),
        .sda_low (model_sda_low)
    );

    always #50 CLK = ~CLK;

    task automatic check_data(input string name,
                              input logic [eeprom_cmd_pkg::DATA_W-1:0] expected,
                              input logic [eeprom_cmd_pkg::DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_nack(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Fail time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t while %s", $time, what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // responses and credits seen on the rising edge
    always @(posedge CLK)
    begin
        if (!RESET && rsp_valid)
        begin
            rsp_seen++;
            if (rsp_seen > RSP_CREDITS + rsp_given)
            begin
                $display("More responses than granted credits at %0t", $time);
                $display("Testbench failed");
                $fatal(1);
            end
            got_rdata_q.push_back(rsp_rdata);
            got_nack_q.push_back(rsp_nack);
        end
        if (!RESET && cmd_credit)
            cmd_returned++;
    end

    task automatic read_stimulus();
        int    fd;
        int    f_op;
        int    f_addr;
        int    f_wd;
        int    f_rd;
        int    f_nk;
        string line;
        fd = $fopen("verification/eeprom_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file");
            $display("Testbench failed");
            $fatal(1);
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_wd, f_rd, f_nk) == 5)
            begin
                op_q.push_back(eeprom_cmd_pkg::cmd_op_t'(f_op[0]));
                addr_q.push_back(f_addr[eeprom_cmd_pkg::ADDR_W-1:0]);
                wdata_q.push_back(f_wd[eeprom_cmd_pkg::DATA_W-1:0]);
                exp_rdata_q.push_back(f_rd[eeprom_cmd_pkg::DATA_W-1:0]);
                exp_nack_q.push_back(f_nk[0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic send_all();
        int waited;
        for (int i = 0; i < op_q.size(); i++)
        begin
            waited = 0;
            while (CMD_DEPTH + cmd_returned - cmd_spent == 0)
            begin
                cmd_valid = 1'b0;
                @(negedge CLK);
                waited++;
                if (waited > TIMEOUT)
                    report_timeout("waiting for a command credit");
            end
            cmd_valid = 1'b1;
            cmd_op    = op_q[i];
            cmd_addr  = addr_q[i];
            cmd_wdata = wdata_q[i];
            cmd_spent++;
            @(negedge CLK);
        end
        cmd_valid = 1'b0;
    endtask

    task automatic collect_all();
        int waited;
        int gap;
        for (int i = 0; i < op_q.size(); i++)
        begin
            waited = 0;
            while (got_rdata_q.size() == 0)
            begin
                @(negedge CLK);
                waited++;
                if (waited > TIMEOUT)
                    report_timeout("waiting for a response");
            end
            check_data("rsp_rdata", exp_rdata_q[i], got_rdata_q.pop_front());
            check_nack("rsp_nack", exp_nack_q[i], got_nack_q.pop_front());
            gap = $random(seed) & 1023; // hold the credit back a while
            repeat (gap) @(negedge CLK);
            rsp_credit = 1'b1;
            rsp_given++;
            @(negedge CLK);
            rsp_credit = 1'b0;
        end
    endtask

    initial
    begin
        CLK          = 1'b0;
        RESET        = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = eeprom_cmd_pkg::CMD_WRITE;
        cmd_addr     = '0;
        cmd_wdata    = '0;
        rsp_credit   = 1'b0;
        cmd_spent    = 0;
        cmd_returned = 0;
        rsp_given    = 0;
        rsp_seen     = 0;
        read_stimulus();
        repeat (4) @(negedge CLK);
        RESET = 1'b0;
        repeat (16)
        begin
            @(negedge CLK);
            check_nack("rsp_valid", 1'b0, rsp_valid);
            check_nack("cmd_credit", 1'b0, cmd_credit);
            check_nack("scl_low", 1'b0, scl_low);
            check_nack("sda_low", 1'b0, sda_low);
        end
        fork
            send_all();
            collect_all();
        join
        repeat (4) @(negedge CLK);
        if (cmd_returned != op_q.size())
        begin
            $display("Fail time=%0t cmd_credit pulses expected=%0d actual=%0d",
                     $time, op_q.size(), cmd_returned);
            $display("Testbench failed");
            $fatal(1);
        end
        else if (got_rdata_q.size() != 0)
        begin
            $display("%0d responses arrived with no command left to answer",
                     got_rdata_q.size());
            $display("Testbench failed");
            $fatal(1);
        end
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verification/eeprom_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_sva #(
    parameter int CMD_DEPTH   = 4,
    parameter int RSP_CREDITS = 2
) (
    input  wire CLK,
    input  wire RESET,
    input  wire scl_low,
    input  wire sda_in,
    input  wire cg_active,
    input  wire cmd_valid,
    input  wire cmd_credit,
    input  wire rsp_valid,
    input  wire rsp_credit
);

    int host_cnt;
    int seq_cnt;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            host_cnt <= CMD_DEPTH;
            seq_cnt  <= RSP_CREDITS;
        end
        else
        begin
            host_cnt <= host_cnt - int'(cmd_valid) + int'(cmd_credit);
            seq_cnt  <= seq_cnt - int'(rsp_valid) + int'(rsp_credit);
        end
    end

    // sda may move under a high scl only inside a start or stop
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (!scl_low && $past(!scl_low) && (sda_in != $past(sda_in)))
            |-> (cg_active || $past(cg_active)))
        else $error("sda changed while scl was high outside a condition");

    cmd_credit_held: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> (host_cnt != 0))
        else $error("command sent without a host credit");

    rsp_credit_held: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |-> (seq_cnt != 0))
        else $error("response sent without a response credit");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_sva #(
    .CMD_DEPTH   (CMD_DEPTH),
    .RSP_CREDITS (RSP_CREDITS)
) u_sva (
    .CLK        (CLK),
    .RESET      (RESET),
    .scl_low    (scl_low),
    .sda_in     (sda_in),
    .cg_active  (cg_active),
    .cmd_valid  (cmd_valid),
    .cmd_credit (cmd_credit),
    .rsp_valid  (rsp_valid),
    .rsp_credit (rsp_credit)
);

`default_nettype wire

// File: verification/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  wire  scl,
    input  wire  sda,
    output logic sda_low
);

    logic [7:0]  mem [2048];
    logic [10:0] ptr;
    logic [7:0]  sr;
    logic [7:0]  rd_byte;
    int          bitn;   // bits seen in the current byte, 9 in the ack slot
    int          nbyte;
    logic        active;
    logic        reading;
    logic        go_read;
    logic        scl_prev;
    logic        sda_prev;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
        sda_low  = 1'b0;
        active   = 1'b0;
        reading  = 1'b0;
        go_read  = 1'b0;
        bitn     = 0;
        nbyte    = 0;
        ptr      = '0;
        sr       = '0;
        rd_byte  = '0;
        scl_prev = 1'b1;
        sda_prev = 1'b1;
    end

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b1 && sda === 1'b0)
        begin
            active  = 1'b1; // start or repeated start
            bitn    = 0;
            nbyte   = 0;
            reading = 1'b0;
            go_read = 1'b0;
            sda_low = 1'b0;
        end
        else if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b0 && sda === 1'b1)
        begin
            active  = 1'b0; // stop
            reading = 1'b0;
            sda_low = 1'b0;
        end
        else if (active && scl_prev === 1'b0 && scl === 1'b1)
        begin
            if (bitn < 8)
            begin
                sr   = {sr[6:0], sda};
                bitn = bitn + 1;
            end
            else
                bitn = 9;
        end
        else if (active && scl_prev === 1'b1 && scl === 1'b0)
        begin
            if (bitn == 8 && reading)
                sda_low = 1'b0; // master owns the ack slot
            else if (bitn == 8)
            begin
                if (nbyte == 0)
                begin
                    if (sr[7:4] == eeprom_bus_pkg::DEV_CODE && sr[3:1] < 3'd6)
                    begin
                        ptr[10:8] = sr[3:1];
                        go_read   = sr[0];
                        sda_low   = 1'b1;
                    end
                    else
                        active = 1'b0; // pages 6 and 7 stay silent
                end
                else if (nbyte == 1)
                begin
                    ptr[7:0] = sr;
                    sda_low  = 1'b1;
                end
                else
                begin
                    mem[ptr] = sr;
                    sda_low  = 1'b1;
                end
                nbyte = nbyte + 1;
            end
            else if (bitn == 9)
            begin
                bitn    = 0;
                sda_low = 1'b0;
                if (reading)
                    reading = 1'b0;
                else if (go_read)
                begin
                    go_read = 1'b0;
                    reading = 1'b1;
                    rd_byte = mem[ptr];
                    sda_low = !rd_byte[7];
                end
            end
            else if (reading)
                sda_low = !rd_byte[7 - bitn];
        end
        scl_prev = scl;
        sda_prev = sda;
    end

endmodule

`default_nettype wire

// File: logic/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top #(
    parameter int CMD_DEPTH   = 4,
    parameter int RSP_CREDITS = 2,
    parameter int QTR_CYCLES  = 4
) (
    input  wire                                 CLK,
    input  wire                                 RESET,
    input  wire                                 cmd_valid,
    input  wire eeprom_cmd_pkg::cmd_op_t        cmd_op,
    input  wire [eeprom_cmd_pkg::ADDR_W-1:0]    cmd_addr,
    input  wire [eeprom_cmd_pkg::DATA_W-1:0]    cmd_wdata,
    output logic                                cmd_credit,
    output logic                                rsp_valid,
    output logic [eeprom_cmd_pkg::DATA_W-1:0]   rsp_rdata,
    output logic                                rsp_nack,
    input  wire                                 rsp_credit,
    output logic                                scl_low,
    output logic                                sda_low,
    input  wire                                 sda_in
);

    logic                       ent_valid;
    logic                       ent_take;
    eeprom_cmd_pkg::cmd_entry_t ent_data;
    logic                       qtick;
    logic                       cond_go;
    logic                       cond_done;
    eeprom_bus_pkg::cond_op_t   cond_op;
    logic                       byte_go;
    logic                       byte_done;
    eeprom_bus_pkg::byte_dir_t  byte_dir;
    logic [7:0]                 byte_tx;
    logic [7:0]                 byte_rx;
    logic                       ack_out;
    logic                       ack_in;
    logic                       cg_scl_low;
    logic                       cg_sda_low;
    logic                       cg_active;
    logic                       bs_scl_low;
    logic                       bs_sda_low;
    logic                       bs_active;

    eeprom_cmd_fifo #(
        .CMD_DEPTH (CMD_DEPTH)
    ) u_fifo (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .ent_take   (ent_take),
        .cmd_credit (cmd_credit),
        .ent_valid  (ent_valid),
        .ent_data   (ent_data)
    );

    eeprom_sequencer #(
        .RSP_CREDITS (RSP_CREDITS),
        .QTR_CYCLES  (QTR_CYCLES)
    ) u_seq (
        .CLK        (CLK),
        .RESET      (RESET),
        .ent_valid  (ent_valid),
        .ent_data   (ent_data),
        .rsp_credit (rsp_credit),
        .cond_done  (cond_done),
        .byte_done  (byte_done),
        .byte_rx    (byte_rx),
        .ack_in     (ack_in),
        .cg_scl_low (cg_scl_low),
        .cg_sda_low (cg_sda_low),
        .cg_active  (cg_active),
        .bs_scl_low (bs_scl_low),
        .bs_sda_low (bs_sda_low),
        .bs_active  (bs_active),
        .ent_take   (ent_take),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_nack   (rsp_nack),
        .qtick      (qtick),
        .cond_go    (cond_go),
        .cond_op    (cond_op),
        .byte_go    (byte_go),
        .byte_dir   (byte_dir),
        .byte_tx    (byte_tx),
        .ack_out    (ack_out),
        .scl_low    (scl_low),
        .sda_low    (sda_low)
    );

    eeprom_cond_gen u_cond (
        .CLK        (CLK),
        .RESET      (RESET),
        .qtick      (qtick),
        .cond_go    (cond_go),
        .cond_op    (cond_op),
        .cond_done  (cond_done),
        .cg_scl_low (cg_scl_low),
        .cg_sda_low (cg_sda_low),
        .cg_active  (cg_active)
    );

    eeprom_byte_shifter u_shift (
        .CLK        (CLK),
        .RESET      (RESET),
        .qtick      (qtick),
        .byte_go    (byte_go),
        .byte_dir   (byte_dir),
        .byte_tx    (byte_tx),
        .ack_out    (ack_out),
        .sda_in     (sda_in),
        .byte_done  (byte_done),
        .byte_rx    (byte_rx),
        .ack_in     (ack_in),
        .bs_scl_low (bs_scl_low),
        .bs_sda_low (bs_sda_low),
        .bs_active  (bs_active)
    );

endmodule

`default_nettype wire

// File: logic/eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_sequencer #(
    parameter int RSP_CREDITS = 2,
    parameter int QTR_CYCLES  = 4
) (
    input  wire                                 CLK,
    input  wire                                 RESET,
    input  wire                                 ent_valid,
    input  wire eeprom_cmd_pkg::cmd_entry_t     ent_data,
    input  wire                                 rsp_credit,
    input  wire                                 cond_done,
    input  wire                                 byte_done,
    input  wire [7:0]                           byte_rx,
    input  wire                                 ack_in,
    input  wire                                 cg_scl_low,
    input  wire                                 cg_sda_low,
    input  wire                                 cg_active,
    input  wire                                 bs_scl_low,
    input  wire                                 bs_sda_low,
    input  wire                                 bs_active,
    output logic                                ent_take,
    output logic                                rsp_valid,
    output logic [eeprom_cmd_pkg::DATA_W-1:0]   rsp_rdata,
    output logic                                rsp_nack,
    output logic                                qtick,
    output logic                                cond_go,
    output eeprom_bus_pkg::cond_op_t            cond_op,
    output logic                                byte_go,
    output eeprom_bus_pkg::byte_dir_t           byte_dir,
    output logic [7:0]                          byte_tx,
    output logic                                ack_out,
    output logic                                scl_low,
    output logic                                sda_low
);

    localparam int CNT_W = $clog2(RSP_CREDITS + 1);
    localparam int Q_W   = $clog2(QTR_CYCLES);

    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA_W,
        ST_RESTART,
        ST_CTRL_R,
        ST_DATA_R,
        ST_STOP
    } state_t;

    state_t                     state;
    state_t                     next_state;
    logic                       launch; // start the engine for the new phase
    logic                       is_cond;
    logic [CNT_W-1:0]           rsp_cnt;
    logic [Q_W-1:0]             qcnt;
    eeprom_cmd_pkg::cmd_entry_t cmd;

    assign ent_take = (state == ST_IDLE) && ent_valid && (rsp_cnt != '0) && !rsp_valid;

    always_comb
    begin
        case (state)
            ST_START:   next_state = ST_CTRL_W;
            ST_CTRL_W:  next_state = ST_ADDR;
            ST_ADDR:    next_state = (cmd.op == eeprom_cmd_pkg::CMD_WRITE) ? ST_DATA_W
                                                                            : ST_RESTART;
            ST_DATA_W:  next_state = ST_STOP;
            ST_RESTART: next_state = ST_CTRL_R;
            ST_CTRL_R:  next_state = ST_DATA_R;
            ST_DATA_R:  next_state = ST_STOP;
            default:    next_state = ST_IDLE;
        endcase
        if (byte_done && byte_dir == eeprom_bus_pkg::BYTE_SEND && !ack_in)
            next_state = ST_STOP; // no ack, finish with a stop
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            launch    <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_cnt   <= CNT_W'(RSP_CREDITS);
        end
        else
        begin
            launch    <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_cnt   <= rsp_cnt + CNT_W'(rsp_credit) - CNT_W'(rsp_valid);
            if (ent_take)
            begin
                state  <= ST_START;
                launch <= 1'b1;
            end
            else if (cond_done || byte_done)
            begin
                state     <= next_state;
                launch    <= (state != ST_STOP);
                rsp_valid <= (state == ST_STOP);
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (ent_take)
        begin
            cmd       <= ent_data;
            rsp_nack  <= 1'b0;
            rsp_rdata <= '0;
        end
        else if (byte_done)
        begin
            if (byte_dir == eeprom_bus_pkg::BYTE_SEND && !ack_in)
                rsp_nack <= 1'b1;
            if (state == ST_DATA_R)
                rsp_rdata <= byte_rx;
        end
    end

    assign is_cond = (state == ST_START) || (state == ST_RESTART) || (state == ST_STOP);
    assign cond_go = launch && is_cond;
    assign byte_go = launch && !is_cond;
    assign ack_out = 1'b0; // single byte read ends with a master nack

    always_comb
    begin
        case (state)
            ST_RESTART: cond_op = eeprom_bus_pkg::COND_RESTART;
            ST_STOP:    cond_op = eeprom_bus_pkg::COND_STOP;
            default:    cond_op = eeprom_bus_pkg::COND_START;
        endcase
        byte_dir = (state == ST_DATA_R) ? eeprom_bus_pkg::BYTE_RECV : eeprom_bus_pkg::BYTE_SEND;
        case (state)
            ST_CTRL_W: byte_tx = {eeprom_bus_pkg::DEV_CODE, cmd.addr[10:8], 1'b0};
            ST_ADDR:   byte_tx = cmd.addr[7:0];
            ST_DATA_W: byte_tx = cmd.wdata;
            ST_CTRL_R: byte_tx = {eeprom_bus_pkg::DEV_CODE, cmd.addr[10:8], 1'b1};
            default:   byte_tx = '0;
        endcase
    end

    // quarter timer, realigned on every engine start
    always_ff @(posedge CLK)
    begin
        if (RESET || launch || qtick)
            qcnt <= '0;
        else
            qcnt <= qcnt + 1'b1;
    end

    assign qtick = (qcnt == Q_W'(QTR_CYCLES - 1));

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_low <= 1'b0;
            sda_low <= 1'b0;
        end
        else if (cg_active)
        begin
            scl_low <= cg_scl_low;
            sda_low <= cg_sda_low;
        end
        else if (bs_active)
        begin
            scl_low <= bs_scl_low;
            sda_low <= bs_sda_low;
        end
        else
            sda_low <= 1'b0; // scl keeps its level between phases
    end

endmodule

`default_nettype wire

// File: logic/eeprom_byte_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_byte_shifter (
    input  wire                             CLK,
    input  wire                             RESET,
    input  wire                             qtick,
    input  wire                             byte_go,
    input  wire eeprom_bus_pkg::byte_dir_t  byte_dir,
    input  wire [7:0]                       byte_tx,
    input  wire                             ack_out,
    input  wire                             sda_in,
    output logic                            byte_done,
    output logic [7:0]                      byte_rx,
    output logic                            ack_in,
    output logic                            bs_scl_low,
    output logic                            bs_sda_low,
    output logic                            bs_active
);

    eeprom_bus_pkg::byte_dir_t dir;
    logic [7:0]                tx_sr;
    logic                      ack_r;   // master ack for a received byte
    logic [3:0]                bit_cnt; // 0..7 data, 8 ack slot
    logic [1:0]                q;
    logic                      ack_slot;

    assign ack_slot = (bit_cnt == 4'd8);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            bs_active <= 1'b0;
            byte_done <= 1'b0;
            bit_cnt   <= '0;
            q         <= '0;
        end
        else
        begin
            byte_done <= 1'b0;
            if (byte_go)
            begin
                bs_active <= 1'b1;
                bit_cnt   <= '0;
                q         <= '0;
            end
            else if (bs_active && qtick)
            begin
                q <= q + 1'b1;
                if (q == 2'd3)
                begin
                    if (ack_slot)
                    begin
                        bs_active <= 1'b0;
                        byte_done <= 1'b1;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (byte_go)
        begin
            dir   <= byte_dir;
            tx_sr <= byte_tx;
            ack_r <= ack_out;
        end
        else if (bs_active && qtick)
        begin
            if (q == 2'd1) // middle of scl high
            begin
                if (ack_slot)
                    ack_in <= ~sda_in;
                else
                    byte_rx <= {byte_rx[6:0], sda_in};
            end
            if (q == 2'd3)
                tx_sr <= {tx_sr[6:0], 1'b0}; // next bit while scl low
        end
    end

    assign bs_scl_low = (q == 2'd0) || (q == 2'd3);

    always_comb
    begin
        if (dir == eeprom_bus_pkg::BYTE_SEND)
            bs_sda_low = !ack_slot && !tx_sr[7]; // slave drives the ack
        else
            bs_sda_low = ack_slot && ack_r;
    end

endmodule

`default_nettype wire

// File: logic/eeprom_cond_gen.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_cond_gen (
    input  wire                             CLK,
    input  wire                             RESET,
    input  wire                             qtick,
    input  wire                             cond_go,
    input  wire eeprom_bus_pkg::cond_op_t   cond_op,
    output logic                            cond_done,
    output logic                            cg_scl_low,
    output logic                            cg_sda_low,
    output logic                            cg_active
);

    eeprom_bus_pkg::cond_op_t op;
    logic [1:0]               q; // quarter within the condition

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cg_active <= 1'b0;
            cond_done <= 1'b0;
            q         <= '0;
        end
        else
        begin
            cond_done <= 1'b0;
            if (cond_go)
            begin
                cg_active <= 1'b1;
                q         <= '0;
            end
            else if (cg_active && qtick)
            begin
                if (q == 2'd3)
                begin
                    cg_active <= 1'b0;
                    cond_done <= 1'b1;
                end
                else
                    q <= q + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cond_go)
            op <= cond_op;
    end

    // start:   released, released, sda low, scl low
    // restart: same, but scl still low in the first quarter
    // stop:    both low, scl up, scl up, sda up
    always_comb
    begin
        if (op == eeprom_bus_pkg::COND_STOP)
        begin
            cg_scl_low = (q == 2'd0);
            cg_sda_low = (q != 2'd3);
        end
        else
        begin
            cg_scl_low = (q == 2'd3) || (q == 2'd0 && op == eeprom_bus_pkg::COND_RESTART);
            cg_sda_low = (q >= 2'd2);
        end
    end

endmodule

`default_nettype wire

// File: logic/eeprom_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_cmd_fifo #(
    parameter int CMD_DEPTH = 4
) (
    input  wire                                 CLK,
    input  wire                                 RESET,
    input  wire                                 cmd_valid,
    input  wire eeprom_cmd_pkg::cmd_op_t        cmd_op,
    input  wire [eeprom_cmd_pkg::ADDR_W-1:0]    cmd_addr,
    input  wire [eeprom_cmd_pkg::DATA_W-1:0]    cmd_wdata,
    input  wire                                 ent_take,
    output logic                                cmd_credit,
    output logic                                ent_valid,
    output eeprom_cmd_pkg::cmd_entry_t          ent_data
);

    localparam int IDX_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    eeprom_cmd_pkg::cmd_entry_t mem [CMD_DEPTH];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [CNT_W-1:0] count;

    function automatic logic [IDX_W-1:0] idx_next(input logic [IDX_W-1:0] idx);
        return (idx == IDX_W'(CMD_DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
            mem[wr_idx] <= '{op: cmd_op, addr: cmd_addr, wdata: cmd_wdata};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_idx     <= '0;
            rd_idx     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            cmd_credit <= ent_take; // credit goes back once the slot is free
            if (cmd_valid)
                wr_idx <= idx_next(wr_idx);
            if (ent_take)
                rd_idx <= idx_next(rd_idx);
            count <= count + CNT_W'(cmd_valid) - CNT_W'(ent_take);
        end
    end

    assign ent_valid = (count != '0);
    assign ent_data  = mem[rd_idx];

endmodule

`default_nettype wire

// File: logic/eeprom_bus_pkg.sv
`default_nettype none

package eeprom_bus_pkg;

    // upper nibble of the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    typedef enum logic [1:0]
    {
        COND_START   = 2'd0,
        COND_RESTART = 2'd1,
        COND_STOP    = 2'd2
    } cond_op_t;

    typedef enum logic
    {
        BYTE_SEND = 1'b0,
        BYTE_RECV = 1'b1
    } byte_dir_t;

endpackage

`default_nettype wire

// File: logic/eeprom_cmd_pkg.sv
`default_nettype none

package eeprom_cmd_pkg;

    localparam int ADDR_W = 11; // 2 Kbyte array
    localparam int DATA_W = 8;

    typedef enum logic
    {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } cmd_op_t;

    // one buffered host command, 20 bits
    typedef struct packed
    {
        cmd_op_t             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } cmd_entry_t;

endpackage

`default_nettype wire
